// ==== common/ray_defs.svh ====
`ifndef RAY_DEFS_SVH
`define RAY_DEFS_SVH

// ray ID width, 512 entries
`define RAY_ID_W 9

`define RAY_DEPTH 512

// origin and direction
`define RAY_VEC_W 192

// sideband tag width
`define SB_WIDTH 8

// memory read latency in cycles
`define RD_LATENCY 2

`endif

// ==== common/ray_pkg.sv ====
`include "ray_defs.svh"

package ray_pkg;

	// ray identifier, indexes the ray memory
	typedef logic [`RAY_ID_W-1:0] ray_id_t;

	// stored ray vector
	typedef logic [`RAY_VEC_W-1:0] ray_vec_t;

	// write loader states
	typedef enum logic {
		LOAD_PASS,
		LOAD_HOLD
	} load_state_t;

endpackage : ray_pkg

// ==== hw/pipe_valid_stall.sv ====
`timescale 1ns/10ps

module pipe_valid_stall #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 2
) (
	input  logic                         clk,
	input  logic                         rst_n,

	input  logic                         us_valid,
	input  logic [WIDTH-1:0]             us_data,
	output logic                         us_stall,

	output logic                         ds_valid,
	output logic [WIDTH-1:0]             ds_data,

	// downstream FIFO is sized DEPTH+1, so this width matches its count
	input  logic [$clog2(DEPTH+2)-1:0]   num_left_in_fifo
);

	localparam int CNT_W = $clog2(DEPTH + 2);

	logic [DEPTH-1:0] valid_q;
	logic [WIDTH-1:0] data_q [DEPTH];
	logic [CNT_W-1:0] in_flight;
	logic             accept;

	// items already promised a FIFO slot
	always_comb begin
		in_flight = '0;
		for (int i = 0; i < DEPTH; i++) begin
			in_flight = in_flight + CNT_W'(valid_q[i]);
		end
	end

	assign us_stall = (num_left_in_fifo <= in_flight);
	assign accept   = us_valid & ~us_stall;

	assign ds_valid = valid_q[DEPTH-1];
	assign ds_data  = data_q[DEPTH-1];

	// pipe always advances, stall only gates new entries
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= '0;
		end else begin
			valid_q[0] <= accept;
			for (int i = 1; i < DEPTH; i++) begin
				valid_q[i] <= valid_q[i-1];
			end
		end
	end

	always_ff @(posedge clk) begin
		data_q[0] <= us_data;
		for (int i = 1; i < DEPTH; i++) begin
			data_q[i] <= data_q[i-1];
		end
	end

endmodule : pipe_valid_stall

// ==== hw/sync_fifo.sv ====
`timescale 1ns/10ps

module sync_fifo #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 4
) (
	input  logic                         clk,
	input  logic                         rst_n,

	input  logic [WIDTH-1:0]             data_in,
	input  logic                         we,
	input  logic                         re,

	output logic                         empty,
	output logic [WIDTH-1:0]             data_out,
	output logic [$clog2(DEPTH+1)-1:0]   num_left_in_fifo
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             full;
	logic             do_write;
	logic             do_read;

	// wrap for depths that are not a power of two
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign empty            = (count == '0);
	assign full             = (count == CNT_W'(DEPTH));
	assign do_read          = re & ~empty;
	assign do_write         = we & (~full | do_read);
	assign num_left_in_fifo = CNT_W'(DEPTH) - count;

	// head entry
	assign data_out = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_write) begin
			mem[wr_ptr] <= data_in;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_write) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (do_read) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			case ({do_write, do_read})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule : sync_fifo

// ==== raystore/ray_bram.sv ====
`timescale 1ns/10ps
`include "ray_defs.svh"

module ray_bram import ray_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,

	input  logic     we,
	input  ray_id_t  waddr,
	input  ray_vec_t wdata,

	input  ray_id_t  raddr,
	output ray_vec_t q
);

	ray_vec_t mem [`RAY_DEPTH];
	ray_vec_t rd_word;

	always_ff @(posedge clk) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
	end

	// read sees the array before a write on the same edge
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_word <= '0;
			q       <= '0;
		end else begin
			rd_word <= mem[raddr];
			q       <= rd_word;
		end
	end

endmodule : ray_bram

// ==== raystore/raystore.sv ====
`timescale 1ns/10ps
`include "ray_defs.svh"

module raystore import ray_pkg::*; #(
	parameter int SB_WIDTH = `SB_WIDTH
) (
	input  logic                clk,
	input  logic                rst_n,

	input  logic                us_valid,
	input  logic [SB_WIDTH-1:0] us_sb_data,
	input  ray_id_t             raddr,
	output logic                us_stall,

	input  logic                we,
	input  ray_vec_t            wdata,
	input  ray_id_t             waddr,

	output logic                ds_valid,
	output logic [SB_WIDTH-1:0] ds_sb_data,
	output ray_vec_t            ds_rd_data,
	input  logic                ds_stall
);

	// one slot per item in flight plus one being drained
	localparam int FIFO_DEPTH = `RD_LATENCY + 1;
	localparam int LEFT_W     = $clog2(FIFO_DEPTH + 1);

	typedef struct packed {
		logic [SB_WIDTH-1:0] sb_data;
		ray_vec_t            rd_data;
	} rs_entry_t;

	logic                pvs_ds_valid;
	logic [SB_WIDTH-1:0] pvs_ds_data;
	ray_vec_t            bram_q;

	logic [LEFT_W-1:0]   num_left_in_fifo;
	logic                fifo_we;
	logic                fifo_re;
	logic                fifo_empty;
	rs_entry_t           fifo_din;
	rs_entry_t           fifo_dout;

	// tag and data line up at the pipe tail
	assign fifo_din.sb_data = pvs_ds_data;
	assign fifo_din.rd_data = bram_q;
	assign fifo_we          = pvs_ds_valid;
	assign fifo_re          = ~fifo_empty & ~ds_stall;

	assign ds_valid   = ~fifo_empty;
	assign ds_sb_data = fifo_dout.sb_data;
	assign ds_rd_data = fifo_dout.rd_data;

	pipe_valid_stall #(.WIDTH(SB_WIDTH), .DEPTH(`RD_LATENCY)) i_pvs (
		.clk,
		.rst_n,
		.us_valid,
		.us_data          (us_sb_data),
		.us_stall,
		.ds_valid         (pvs_ds_valid),
		.ds_data          (pvs_ds_data),
		.num_left_in_fifo
	);

	ray_bram i_bram (
		.clk,
		.rst_n,
		.we,
		.waddr,
		.wdata,
		.raddr,
		.q     (bram_q)
	);

	sync_fifo #(.WIDTH($bits(rs_entry_t)), .DEPTH(FIFO_DEPTH)) i_fifo (
		.clk,
		.rst_n,
		.data_in          (fifo_din),
		.we               (fifo_we),
		.re               (fifo_re),
		.empty            (fifo_empty),
		.data_out         (fifo_dout),
		.num_left_in_fifo
	);

endmodule : raystore

// ==== raystore/ray_loader.sv ====
`timescale 1ns/10ps

module ray_loader import ray_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,

	input  logic     w_valid,
	input  ray_id_t  w_id,
	input  ray_vec_t w_data,
	output logic     w_ready,

	input  logic     rd_accept,
	input  ray_id_t  rd_id,

	output logic     we,
	output ray_id_t  waddr,
	output ray_vec_t wdata
);

	load_state_t state;
	load_state_t state_next;
	ray_id_t     hold_id;
	ray_vec_t    hold_data;
	logic        collide;

	assign w_ready = (state == LOAD_PASS);
	// write hitting the ray being read this cycle
	assign collide = w_valid & rd_accept & (w_id == rd_id);

	always_comb begin
		state_next = state;
		we         = 1'b0;
		waddr      = w_id;
		wdata      = w_data;
		case (state)
			LOAD_PASS: begin
				if (collide) begin
					state_next = LOAD_HOLD;
				end else begin
					we = w_valid;
				end
			end
			LOAD_HOLD: begin
				// deferred write goes first
				we         = 1'b1;
				waddr      = hold_id;
				wdata      = hold_data;
				state_next = LOAD_PASS;
			end
			default: state_next = LOAD_PASS;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= LOAD_PASS;
		end else begin
			state <= state_next;
		end
	end

	always_ff @(posedge clk) begin
		if (state == LOAD_PASS && collide) begin
			hold_id   <= w_id;
			hold_data <= w_data;
		end
	end

endmodule : ray_loader

// ==== hw/ray_subsys_top.sv ====
`timescale 1ns/10ps
`include "ray_defs.svh"

module ray_subsys_top import ray_pkg::*; (
	input  logic                 clk,
	input  logic                 rst_n,

	// write port
	input  logic                 w_valid,
	input  ray_id_t              w_id,
	input  ray_vec_t             w_data,
	output logic                 w_ready,

	// read request
	input  logic                 rd_valid,
	input  ray_id_t              rd_id,
	input  logic [`SB_WIDTH-1:0] rd_tag,
	output logic                 rd_stall,

	// read result
	output logic                 out_valid,
	output logic [`SB_WIDTH-1:0] out_tag,
	output ray_vec_t             out_data,
	input  logic                 out_stall
);

	logic     rd_accept;
	logic     mem_we;
	ray_id_t  mem_waddr;
	ray_vec_t mem_wdata;

	assign rd_accept = rd_valid & ~rd_stall;

	ray_loader i_loader (
		.clk,
		.rst_n,
		.w_valid,
		.w_id,
		.w_data,
		.w_ready,
		.rd_accept,
		.rd_id,
		.we        (mem_we),
		.waddr     (mem_waddr),
		.wdata     (mem_wdata)
	);

	raystore #(.SB_WIDTH(`SB_WIDTH)) i_raystore (
		.clk,
		.rst_n,
		.us_valid   (rd_valid),
		.us_sb_data (rd_tag),
		.raddr      (rd_id),
		.us_stall   (rd_stall),
		.we         (mem_we),
		.wdata      (mem_wdata),
		.waddr      (mem_waddr),
		.ds_valid   (out_valid),
		.ds_sb_data (out_tag),
		.ds_rd_data (out_data),
		.ds_stall   (out_stall)
	);

endmodule : ray_subsys_top

// ==== tb/tb_ray_subsys.sv ====
`timescale 1ns/10ps
`include "ray_defs.svh"

module tb_ray_subsys import ray_pkg::*; ();

	localparam int CLK_PERIOD = 4;
	localparam int N_BURST    = 8;
	localparam int N_STALL    = 64;
	localparam int N_RANDOM   = 600;
	// single r/w, fill, burst, stall, collision, random
	localparam int TOTAL_OPS  = 2 + `RAY_DEPTH + N_BURST + N_STALL + 3 + 2 * N_RANDOM;
	localparam int TIMEOUT_CYCLES = TOTAL_OPS * 20 + 500;

	logic                 clk = 1'b0;
	logic                 rst_n;
	logic                 w_valid;
	ray_id_t              w_id;
	ray_vec_t             w_data;
	logic                 w_ready;
	logic                 rd_valid;
	ray_id_t              rd_id;
	logic [`SB_WIDTH-1:0] rd_tag;
	logic                 rd_stall;
	logic                 out_valid;
	logic [`SB_WIDTH-1:0] out_tag;
	ray_vec_t             out_data;
	logic                 out_stall;

	// reference model state
	ray_vec_t             ref_mem [`RAY_DEPTH];
	logic                 model_hold;
	ray_id_t              model_hold_id;
	ray_vec_t             model_hold_data;
	logic [`SB_WIDTH-1:0] exp_tags [$];
	ray_vec_t             exp_data [$];
	logic [`SB_WIDTH-1:0] exp_tag;
	ray_vec_t             exp_vec;
	logic                 rd_acc;
	logic                 held_prev;
	logic [`SB_WIDTH-1:0] held_tag;
	ray_vec_t             held_data;

	integer               seed;
	integer               stall_seed;
	logic [31:0]          stall_rnd;
	logic                 stall_en;
	logic [`SB_WIDTH-1:0] tag_cnt;
	int                   err_value;
	int                   err_other;

	ray_subsys_top i_ray_subsys_top (
		.clk, .rst_n,
		.w_valid, .w_id, .w_data, .w_ready,
		.rd_valid, .rd_id, .rd_tag, .rd_stall,
		.out_valid, .out_tag, .out_data, .out_stall
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// every word differs in each address bit
	function automatic ray_vec_t fill_pattern(input ray_id_t id);
		ray_vec_t v;
		for (int i = 0; i < `RAY_VEC_W / 32; i++) begin
			v[i*32 +: 32] = {7'(i), ~id, 16'(id * 16'h9e37 + i)};
		end
		return v;
	endfunction

	function automatic ray_vec_t random_ray();
		ray_vec_t v;
		for (int i = 0; i < `RAY_VEC_W / 32; i++) begin
			v[i*32 +: 32] = $random(seed);
		end
		return v;
	endfunction

	// memory content seen by a read accepted now
	function automatic ray_vec_t expected_ray(input ray_id_t id);
		return ref_mem[id];
	endfunction

	task automatic issue_write(input ray_id_t id, input ray_vec_t data);
		w_valid <= 1'b1;
		w_id    <= id;
		w_data  <= data;
		@(posedge clk);
		while (!w_ready) begin
			@(posedge clk);
		end
		w_valid <= 1'b0;
	endtask

	task automatic issue_read(input ray_id_t id);
		rd_valid <= 1'b1;
		rd_id    <= id;
		rd_tag   <= tag_cnt;
		tag_cnt  = tag_cnt + 1'b1;
		@(posedge clk);
		while (rd_stall) begin
			@(posedge clk);
		end
		rd_valid <= 1'b0;
	endtask

	task automatic wait_idle();
		stall_en <= 1'b0;
		do begin
			@(negedge clk);
		end while (exp_tags.size() != 0);
		// catch a stray extra result
		repeat (`RD_LATENCY + 3) @(posedge clk);
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		assert (got === exp) else begin
			$display("FAILED %s: got %h expected %h", name, got, exp);
			err_value++;
		end
	endtask

	task automatic test_burst();
		int lat;
		fork
			begin
				for (int i = 0; i < N_BURST; i++) begin
					issue_read(ray_id_t'(i * 37 + 3));
				end
			end
			begin
				@(posedge clk);
				while (!(rd_valid && !rd_stall)) begin
					@(posedge clk);
				end
				lat = 0;
				do begin
					@(posedge clk);
					lat++;
				end while (!out_valid && lat < 16);
				assert (lat == `RD_LATENCY + 1) else begin
					$display("FAILED out_valid latency: got %h expected %h", lat, `RD_LATENCY + 1);
					err_value++;
				end
			end
		join
		wait_idle();
	endtask

	task automatic test_collision();
		ray_id_t  id;
		ray_vec_t new_vec;
		id      = 9'h1c3;
		new_vec = random_ray();
		fork
			issue_write(id, new_vec);
			issue_read(id);
		join
		@(posedge clk);
		check_bit("w_ready", w_ready, 1'b0);
		@(posedge clk);
		check_bit("w_ready", w_ready, 1'b1);
		issue_read(id);
		wait_idle();
	endtask

	task automatic test_random();
		int       op;
		ray_id_t  wid;
		ray_id_t  rid;
		ray_vec_t vec;
		stall_en <= 1'b1;
		for (int n = 0; n < N_RANDOM; n++) begin
			op  = $random(seed) & 3;
			wid = ray_id_t'($random(seed));
			rid = (op == 3) ? wid : ray_id_t'($random(seed));
			vec = random_ray();
			case (op)
				0: issue_write(wid, vec);
				1: issue_read(rid);
				default: begin
					fork
						issue_write(wid, vec);
						issue_read(rid);
					join
				end
			endcase
		end
		wait_idle();
	endtask

	always @(posedge clk) begin
		stall_rnd = $random(stall_seed);
		out_stall <= stall_en & stall_rnd[0];
	end

	// compare process and reference memory update
	always @(posedge clk) begin
		if (rst_n) begin
			rd_acc = rd_valid & ~rd_stall;
			if (held_prev) begin
				assert (out_valid && out_tag === held_tag && out_data === held_data) else begin
					$display("held output changed while stalled at %0t", $time);
					err_other++;
				end
			end
			held_prev = out_valid & out_stall;
			held_tag  = out_tag;
			held_data = out_data;

			if (out_valid && !out_stall) begin
				assert (exp_tags.size() != 0) else begin
					$display("a result arrived with no request pending");
					err_other++;
				end
				if (exp_tags.size() != 0) begin
					exp_tag = exp_tags.pop_front();
					exp_vec = exp_data.pop_front();
					assert (out_tag === exp_tag) else begin
						$display("FAILED out_tag: got %h expected %h", out_tag, exp_tag);
						err_value++;
					end
					assert (out_data === exp_vec) else begin
						$display("FAILED out_data: got %h expected %h", out_data, exp_vec);
						err_value++;
					end
				end
			end

			if (rd_acc) begin
				exp_tags.push_back(rd_tag);
				exp_data.push_back(expected_ray(rd_id));
			end

			check_bit("w_ready", w_ready, ~model_hold);
			// a colliding write lands one edge late
			if (model_hold) begin
				ref_mem[model_hold_id] = model_hold_data;
				model_hold = 1'b0;
			end else if (w_valid) begin
				if (rd_acc && w_id == rd_id) begin
					model_hold      = 1'b1;
					model_hold_id   = w_id;
					model_hold_data = w_data;
				end else begin
					ref_mem[w_id] = w_data;
				end
			end
		end
	end

	initial begin
		#(CLK_PERIOD * TIMEOUT_CYCLES);
		$display("timeout: run still busy after %0d cycles", TIMEOUT_CYCLES);
		$display("errors: %0d value mismatches, %0d other failures", err_value, err_other);
		$display("TB FAILED");
		$finish;
	end

	initial begin
		seed       = 42160;
		stall_seed = seed + 1;
		rst_n      = 1'b0;
		w_valid    = 1'b0;
		w_id       = '0;
		w_data     = '0;
		rd_valid   = 1'b0;
		rd_id      = '0;
		rd_tag     = '0;
		out_stall  = 1'b0;
		stall_en   = 1'b0;
		tag_cnt    = '0;
		err_value  = 0;
		err_other  = 0;
		model_hold = 1'b0;
		held_prev  = 1'b0;
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_bit("out_valid", out_valid, 1'b0);
		check_bit("rd_stall", rd_stall, 1'b0);
		check_bit("w_ready", w_ready, 1'b1);
		@(posedge clk);

		issue_write(9'h0a5, random_ray());
		issue_read(9'h0a5);
		wait_idle();

		for (int i = 0; i < `RAY_DEPTH; i++) begin
			issue_write(ray_id_t'(i), fill_pattern(ray_id_t'(i)));
		end
		test_burst();

		stall_en <= 1'b1;
		for (int i = 0; i < N_STALL; i++) begin
			issue_read(ray_id_t'($random(seed)));
		end
		wait_idle();

		test_collision();
		test_random();

		$display("errors: %0d value mismatches, %0d other failures", err_value, err_other);
		if (err_value + err_other == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule : tb_ray_subsys

// ==== compile.f ====
+incdir+common
common/ray_pkg.sv
hw/pipe_valid_stall.sv
hw/sync_fifo.sv
raystore/ray_bram.sv
raystore/raystore.sv
raystore/ray_loader.sv
hw/ray_subsys_top.sv
tb/tb_ray_subsys.sv

// ==== Bender.yml ====
package:
  name: ray_subsys

sources:
  - include_dirs:
      - common
    files:
      - common/ray_pkg.sv
      - hw/pipe_valid_stall.sv
      - hw/sync_fifo.sv
      - raystore/ray_bram.sv
      - raystore/raystore.sv
      - raystore/ray_loader.sv
      - hw/ray_subsys_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - tb/tb_ray_subsys.sv
